// ==== tb.f ====
design/spi_pkg.sv
design/spi_regs.sv
design/spi_bit_mem.sv
design/spi_sequencer.sv
design/spi_core.sv
sim/spi_checker.sv
sim/spi_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the SPI sequencer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module spi_tb -f tb.f -Mdir obj_dir -o spi_tb_sim

./obj_dir/spi_tb_sim

// ==== sim/spi_tb.sv ====
/*
 * Directed testbench for the SPI sequencer
 * drives the host bus, echoes SDI back on SDO and checks readback and counts
 */
`timescale 1ns/10ps

module spi_tb;

    localparam int TIMEOUT_CYCLES = 4000;  // tests take about 550 cycles
    localparam int POLL_LIMIT     = 400;
    localparam int SHORT_BITS     = 12;

    logic                       SPI_CLK;
    logic                       RST;
    logic [spi_pkg::ADDR_W-1:0] bus_addr;
    logic [7:0]                 bus_wdata;
    logic                       bus_wr;
    logic                       bus_rd;
    logic [7:0]                 bus_rdata;
    logic                       sclk;
    logic                       sdo;
    logic                       sdi;
    logic                       sen;
    logic                       sld;

    logic                         invert_loop;
    integer                       seed;
    int                           cycles      = 0;
    int                           sclk_edges  = 0;
    int                           sld_pulses  = 0;
    int                           sen_rises   = 0;
    int                           sen_fall_at = 0;  // cycle of the last sen fall
    int                           sen_gap     = 0;
    logic [spi_pkg::MEM_BITS-1:0] out_word;  // msb-first image of each memory
    logic [spi_pkg::MEM_BITS-1:0] in_word;

    spi_core i_dut (
        .SPI_CLK   (SPI_CLK),
        .RST       (RST),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_wr    (bus_wr),
        .bus_rd    (bus_rd),
        .bus_rdata (bus_rdata),
        .sclk      (sclk),
        .sdo       (sdo),
        .sdi       (sdi),
        .sen       (sen),
        .sld       (sld)
    );

    assign sdo = invert_loop ? ~sdi : sdi;  // device echoes sdi

    always #2 SPI_CLK = ~SPI_CLK;

    always @(posedge sclk) sclk_edges = sclk_edges + 1;
    always @(posedge sen) sen_rises = sen_rises + 1;

    always @(negedge sen) sen_fall_at = cycles;
    always @(posedge sen) sen_gap = cycles - sen_fall_at;  // idle cycles before a transfer

    always @(negedge SPI_CLK) begin
        if (sld) begin
            sld_pulses = sld_pulses + 1;  // sld is stable mid-cycle
        end
    end

    always @(posedge SPI_CLK) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("sim failed");
            $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("sim failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("sim failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    function automatic logic [7:0] byte_of(input logic [spi_pkg::MEM_BITS-1:0] word, input int i);
        return word[spi_pkg::MEM_BITS-1-8*i -: 8];
    endfunction

    task automatic bus_write(input logic [spi_pkg::ADDR_W-1:0] addr, input logic [7:0] data);
        bus_addr  = addr;
        bus_wdata = data;
        bus_wr    = 1'b1;
        @(posedge SPI_CLK);
        #1;
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [spi_pkg::ADDR_W-1:0] addr, output logic [7:0] data);
        bus_addr = addr;
        bus_rd   = 1'b1;
        @(posedge SPI_CLK);
        #1;
        bus_rd = 1'b0;
        data   = bus_rdata;  // one cycle read latency
    endtask

    task automatic read_expect(input logic [spi_pkg::ADDR_W-1:0] addr, input logic [7:0] exp);
        logic [7:0] got;
        bus_read(addr, got);
        check_byte($sformatf("bus_rdata[%0h]", addr), got, exp);
    endtask

    task automatic clear_counts();
        sclk_edges = 0;
        sld_pulses = 0;
        sen_rises  = 0;
    endtask

    task automatic wait_done();
        logic [7:0] flag;
        int         polls;
        flag  = 8'h00;
        polls = 0;
        while (flag[0] !== 1'b1) begin
            if (polls >= POLL_LIMIT) begin
                fail_run("done flag did not come back after start");
            end
            bus_read(spi_pkg::REG_START, flag);
            polls++;
        end
    endtask

    task automatic wait_sld(input int n);
        int waited;
        waited = 0;
        while (sld_pulses < n) begin
            @(posedge SPI_CLK);
            #1;
            waited++;
            if (waited > POLL_LIMIT) begin
                fail_run($sformatf("saw %0d load pulses, waiting for %0d", sld_pulses, n));
            end
        end
    endtask

    task automatic check_defaults();
        int a;
        read_expect(spi_pkg::REG_RESET, 8'(spi_pkg::VERSION));
        read_expect(spi_pkg::REG_START, 8'h01);
        read_expect(spi_pkg::REG_BITS_LO, 8'(spi_pkg::MEM_BITS));
        read_expect(spi_pkg::REG_BITS_HI, 8'(spi_pkg::MEM_BITS >> 8));
        for (a = 5; a <= 8; a++) begin
            read_expect(8'(a), 8'h00);
        end
        read_expect(spi_pkg::REG_REPEAT_0, 8'h01);
        for (a = 10; a <= 12; a++) begin
            read_expect(8'(a), 8'h00);
        end
    endtask

    task automatic load_out_mem();
        int i;
        for (i = 0; i < spi_pkg::MEM_BYTES; i++) begin
            out_word[spi_pkg::MEM_BITS-1-8*i -: 8] = 8'($random(seed));
            bus_write(8'(spi_pkg::OUT_MEM_BASE + i), byte_of(out_word, i));
        end
        for (i = 0; i < spi_pkg::MEM_BYTES; i++) begin
            read_expect(8'(spi_pkg::OUT_MEM_BASE + i), byte_of(out_word, i));
        end
    endtask

    task automatic check_in_mem();
        int i;
        for (i = 0; i < spi_pkg::MEM_BYTES; i++) begin
            read_expect(8'(spi_pkg::IN_MEM_BASE + i), byte_of(in_word, i));
        end
    endtask

    task automatic test_reset_values();
        logic [7:0] wr_val [13];
        int         a;
        check_defaults();
        for (a = 3; a <= 12; a++) begin
            wr_val[a] = 8'($random(seed));
            bus_write(8'(a), wr_val[a]);
        end
        for (a = 3; a <= 12; a++) begin
            read_expect(8'(a), wr_val[a]);
        end
        bus_write(spi_pkg::REG_RESET, 8'h00);
        check_defaults();
    endtask

    task automatic test_loopback_full();
        load_out_mem();
        invert_loop = 1'b0;
        clear_counts();
        bus_write(spi_pkg::REG_START, 8'h00);
        read_expect(spi_pkg::REG_START, 8'h00);  // busy
        wait_done();
        check_count("sclk edges", sclk_edges, spi_pkg::MEM_BITS);
        check_count("sld pulses", sld_pulses, 1);
        in_word = out_word;
        check_in_mem();
    endtask

    task automatic test_short_inverted();
        int k;
        load_out_mem();
        bus_write(spi_pkg::REG_BITS_LO, 8'(SHORT_BITS));
        bus_write(spi_pkg::REG_BITS_HI, 8'h00);
        invert_loop = 1'b1;
        clear_counts();
        bus_write(spi_pkg::REG_START, 8'h00);
        wait_done();
        check_count("sclk edges", sclk_edges, SHORT_BITS);
        check_count("sld pulses", sld_pulses, 1);
        for (k = 0; k < SHORT_BITS; k++) begin
            in_word[spi_pkg::MEM_BITS-1-k] = ~out_word[spi_pkg::MEM_BITS-1-k];
        end
        check_in_mem();
    endtask

    task automatic test_repeat_wait();
        invert_loop = 1'b0;
        bus_write(spi_pkg::REG_WAIT_0, 8'd5);
        bus_write(spi_pkg::REG_REPEAT_0, 8'd3);
        clear_counts();
        bus_write(spi_pkg::REG_START, 8'h00);
        wait_sld(1);
        read_expect(spi_pkg::REG_START, 8'h00);
        wait_sld(2);
        read_expect(spi_pkg::REG_START, 8'h00);
        wait_done();
        check_count("sld pulses", sld_pulses, 3);
        check_count("sclk edges", sclk_edges, 3 * SHORT_BITS);
        check_count("sen gap", sen_gap, 5);  // wait cycles between transfers
    endtask

    task automatic test_endless_repeat();
        bus_write(spi_pkg::REG_REPEAT_0, 8'd0);
        bus_write(spi_pkg::REG_START, 8'h00);
        repeat (200) begin
            @(posedge SPI_CLK);
            #1;
        end
        clear_counts();
        repeat (40) begin
            @(posedge SPI_CLK);
            #1;
        end
        if (sen_rises < 2) begin
            fail_run("sen stopped toggling with an endless repeat count");
        end
        read_expect(spi_pkg::REG_START, 8'h00);
        bus_write(spi_pkg::REG_RESET, 8'h00);
        clear_counts();
        repeat (50) begin
            @(posedge SPI_CLK);
            #1;
        end
        check_count("sen rises", sen_rises, 0);
        check_count("sld pulses", sld_pulses, 0);
        check_defaults();
    endtask

    initial begin
        SPI_CLK     = 1'b0;
        RST         = 1'b1;
        bus_addr    = '0;
        bus_wdata   = 8'h00;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        invert_loop = 1'b0;
        seed        = 61;
        out_word    = '0;
        in_word     = '0;
        repeat (3) @(posedge SPI_CLK);
        #1;
        RST = 1'b0;
        test_reset_values();
        test_loopback_full();
        test_short_inverted();
        test_repeat_wait();
        test_endless_repeat();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== sim/spi_checker.sv ====
/*
 * SPI sequencer protocol assertions
 * bound into every spi_sequencer instance
 */
`timescale 1ns/10ps

module spi_checker (
    input logic SPI_CLK,
    input logic RST,
    input logic sen,
    input logic sdi,
    input logic sld
);

    sld_single: assert property (@(posedge SPI_CLK) disable iff (RST) sld |=> !sld)
        else $error("sld high for two cycles in a row");

    // sen and sdi both move on the falling edge
    sdi_quiet: assert property (@(posedge SPI_CLK) disable iff (RST) !sen |-> !sdi)
        else $error("sdi high while sen is low");

    sen_after_reset: assert property (@(posedge SPI_CLK) RST |=> !sen)
        else $error("sen high in the cycle after reset");

endmodule

bind spi_sequencer spi_checker i_checker (
    .SPI_CLK (SPI_CLK),
    .RST     (RST),
    .sen     (sen),
    .sdi     (sdi),
    .sld     (sld)
);

// ==== design/spi_core.sv ====
/*
 * SPI sequencer top level
 * host register file, output and input pattern memories, sequencer
 */
`timescale 1ns/10ps

module spi_core (
    input  logic                       SPI_CLK,
    input  logic                       RST,
    input  logic [spi_pkg::ADDR_W-1:0] bus_addr,
    input  logic [7:0]                 bus_wdata,
    input  logic                       bus_wr,
    input  logic                       bus_rd,
    output logic [7:0]                 bus_rdata,
    output logic                       sclk,
    input  logic                       sdo,
    output logic                       sdi,
    output logic                       sen,
    output logic                       sld
);

    logic                          rst;
    logic                          soft_rst;
    logic                          start;
    logic                          done;
    logic [15:0]                   conf_bits;
    logic [31:0]                   conf_wait;
    logic [31:0]                   conf_repeat;
    logic                          out_mem_we;
    logic [7:0]                    out_mem_rdata;
    logic [7:0]                    in_mem_rdata;
    logic                          tx_bit;
    logic [spi_pkg::BIT_CNT_W-1:0] tx_bit_addr;
    logic [spi_pkg::BIT_CNT_W-1:0] rx_bit_addr;
    logic                          rx_wr;

    assign rst = RST | soft_rst;

    spi_regs i_regs (
        .SPI_CLK       (SPI_CLK),
        .RST           (rst),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .bus_wr        (bus_wr),
        .done          (done),
        .out_mem_rdata (out_mem_rdata),
        .in_mem_rdata  (in_mem_rdata),
        .bus_rdata     (bus_rdata),
        .soft_rst      (soft_rst),
        .start         (start),
        .conf_bits     (conf_bits),
        .conf_wait     (conf_wait),
        .conf_repeat   (conf_repeat),
        .out_mem_we    (out_mem_we)
    );

    // both bases are 4-byte aligned
    spi_bit_mem i_out_mem (
        .SPI_CLK    (SPI_CLK),
        .byte_addr  (bus_addr[1:0]),
        .byte_we    (out_mem_we),
        .byte_wdata (bus_wdata),
        .byte_rdata (out_mem_rdata),
        .bit_addr   (tx_bit_addr),
        .bit_we     (1'b0),
        .bit_wdata  (1'b0),
        .bit_rdata  (tx_bit)
    );

    spi_bit_mem i_in_mem (
        .SPI_CLK    (SPI_CLK),
        .byte_addr  (bus_addr[1:0]),
        .byte_we    (1'b0),
        .byte_wdata (8'h00),
        .byte_rdata (in_mem_rdata),
        .bit_addr   (rx_bit_addr),
        .bit_we     (rx_wr),
        .bit_wdata  (sdo),
        .bit_rdata  ()
    );

    spi_sequencer i_seq (
        .SPI_CLK     (SPI_CLK),
        .RST         (rst),
        .start       (start),
        .conf_bits   (conf_bits),
        .conf_wait   (conf_wait),
        .conf_repeat (conf_repeat),
        .tx_bit      (tx_bit),
        .tx_bit_addr (tx_bit_addr),
        .rx_bit_addr (rx_bit_addr),
        .rx_wr       (rx_wr),
        .sclk        (sclk),
        .sen         (sen),
        .sdi         (sdi),
        .sld         (sld),
        .done        (done),
        .sdo         (sdo)
    );

endmodule

// ==== design/spi_sequencer.sv ====
/*
 * SPI transfer sequencer
 * shifts conf_bits bits per transfer, waits, repeats, and pulses load and done
 */
`timescale 1ns/10ps

module spi_sequencer (
    input  logic                          SPI_CLK,
    input  logic                          RST,
    input  logic                          start,
    input  logic [15:0]                   conf_bits,
    input  logic [31:0]                   conf_wait,
    input  logic [31:0]                   conf_repeat,
    input  logic                          tx_bit,
    output logic [spi_pkg::BIT_CNT_W-1:0] tx_bit_addr,
    output logic [spi_pkg::BIT_CNT_W-1:0] rx_bit_addr,
    output logic                          rx_wr,
    output logic                          sclk,
    output logic                          sen,
    output logic                          sdi,
    output logic                          sld,
    output logic                          done,
    input  logic                          sdo
);

    spi_pkg::seq_state_e state;
    logic [15:0]         bit_cnt;
    logic [31:0]         wait_cnt;
    logic [31:0]         rep_cnt;
    logic                en;
    logic                more_reps;
    logic                last_xfer;
    logic                en_d1;
    logic                en_d2;

    assign en          = (state == spi_pkg::SEQ_SHIFT);
    assign more_reps   = (conf_repeat == 32'd0) || (rep_cnt < conf_repeat);  // 0 runs forever
    assign tx_bit_addr = bit_cnt[spi_pkg::BIT_CNT_W-1:0];
    assign rx_bit_addr = bit_cnt[spi_pkg::BIT_CNT_W-1:0];
    assign rx_wr       = en;  // sdo goes straight to the input memory
    assign sclk        = SPI_CLK & sen;

    always_ff @(posedge SPI_CLK) begin
        if (RST) begin
            state     <= spi_pkg::SEQ_IDLE;
            bit_cnt   <= 16'd0;
            wait_cnt  <= 32'd0;
            rep_cnt   <= 32'd0;
            last_xfer <= 1'b0;
        end else if (start && conf_bits != 16'd0) begin
            state     <= spi_pkg::SEQ_SHIFT;
            bit_cnt   <= 16'd0;
            rep_cnt   <= 32'd1;
            last_xfer <= 1'b0;
        end else begin
            case (state)
                spi_pkg::SEQ_SHIFT: begin
                    if (bit_cnt + 16'd1 >= conf_bits) begin
                        state     <= spi_pkg::SEQ_WAIT;
                        wait_cnt  <= 32'd1;
                        last_xfer <= !more_reps;
                    end else begin
                        bit_cnt <= bit_cnt + 16'd1;
                    end
                end
                spi_pkg::SEQ_WAIT: begin
                    // at least one idle cycle so sen drops between transfers
                    if (wait_cnt >= conf_wait) begin
                        if (more_reps) begin
                            state   <= spi_pkg::SEQ_SHIFT;
                            bit_cnt <= 16'd0;
                            rep_cnt <= rep_cnt + 32'd1;
                        end else begin
                            state <= spi_pkg::SEQ_IDLE;
                        end
                    end else begin
                        wait_cnt <= wait_cnt + 32'd1;
                    end
                end
                default: state <= spi_pkg::SEQ_IDLE;
            endcase
        end
    end

    // load pulse on the delayed falling edge of en
    always_ff @(posedge SPI_CLK) begin
        if (RST) begin
            en_d1 <= 1'b0;
            en_d2 <= 1'b0;
            sld   <= 1'b0;
            done  <= 1'b0;
        end else begin
            en_d1 <= en;
            en_d2 <= en_d1;
            sld   <= en_d2 & ~en_d1;
            done  <= en_d2 & ~en_d1 & last_xfer;
        end
    end

    always_ff @(negedge SPI_CLK) begin
        if (RST) begin
            sen <= 1'b0;
            sdi <= 1'b0;
        end else begin
            sen <= en;
            sdi <= tx_bit & en;
        end
    end

endmodule

// ==== design/spi_bit_mem.sv ====
/*
 * Pattern memory, byte port for the host and bit port for the shifter
 * bits are stored MSB-first within each byte
 */
`timescale 1ns/10ps

module spi_bit_mem (
    input  logic                          SPI_CLK,
    input  logic [1:0]                    byte_addr,
    input  logic                          byte_we,
    input  logic [7:0]                    byte_wdata,
    output logic [7:0]                    byte_rdata,
    input  logic [spi_pkg::BIT_CNT_W-1:0] bit_addr,
    input  logic                          bit_we,
    input  logic                          bit_wdata,
    output logic                          bit_rdata
);

    logic [7:0]                   mem [spi_pkg::MEM_BYTES];
    logic [spi_pkg::BIT_CNT_W-4:0] bit_byte;
    logic [2:0]                   bit_pos;
    logic                         bit_in_range;

    assign bit_byte     = bit_addr[spi_pkg::BIT_CNT_W-1:3];
    assign bit_pos      = 3'd7 - bit_addr[2:0];  // msb first
    assign bit_in_range = (bit_addr < spi_pkg::MEM_BITS);

    always_ff @(posedge SPI_CLK) begin
        if (byte_we) begin
            mem[byte_addr] <= byte_wdata;
        end
        if (bit_we && bit_in_range) begin
            mem[bit_byte[1:0]][bit_pos] <= bit_wdata;
        end
    end

    always_ff @(posedge SPI_CLK) begin
        byte_rdata <= mem[byte_addr];
    end

    always_comb begin
        if (bit_in_range) begin
            bit_rdata = mem[bit_byte[1:0]][bit_pos];
        end else begin
            bit_rdata = 1'b0;
        end
    end

endmodule

// ==== design/spi_regs.sv ====
/*
 * SPI register file
 * config bytes, start and soft reset strobes, done flag and bus readback
 */
`timescale 1ns/10ps

module spi_regs (
    input  logic                       SPI_CLK,
    input  logic                       RST,
    input  logic [spi_pkg::ADDR_W-1:0] bus_addr,
    input  logic [7:0]                 bus_wdata,
    input  logic                       bus_wr,
    input  logic                       done,
    input  logic [7:0]                 out_mem_rdata,
    input  logic [7:0]                 in_mem_rdata,
    output logic [7:0]                 bus_rdata,
    output logic                       soft_rst,
    output logic                       start,
    output logic [15:0]                conf_bits,
    output logic [31:0]                conf_wait,
    output logic [31:0]                conf_repeat,
    output logic                       out_mem_we
);

    logic [spi_pkg::ADDR_W-1:0] prev_addr;
    logic [7:0]                 reg_rdata;
    logic                       done_flag;

    assign soft_rst   = bus_wr && (bus_addr == spi_pkg::REG_RESET);
    assign start      = bus_wr && (bus_addr == spi_pkg::REG_START);
    assign out_mem_we = bus_wr && (bus_addr >= spi_pkg::OUT_MEM_BASE)
                               && (bus_addr < spi_pkg::IN_MEM_BASE);

    always_ff @(posedge SPI_CLK) begin
        if (RST) begin
            conf_bits   <= 16'(spi_pkg::MEM_BITS);
            conf_wait   <= 32'd0;
            conf_repeat <= 32'd1;
        end else if (bus_wr) begin
            case (bus_addr)
                spi_pkg::REG_BITS_LO:  conf_bits[7:0]     <= bus_wdata;
                spi_pkg::REG_BITS_HI:  conf_bits[15:8]    <= bus_wdata;
                spi_pkg::REG_WAIT_0:   conf_wait[7:0]     <= bus_wdata;
                spi_pkg::REG_WAIT_1:   conf_wait[15:8]    <= bus_wdata;
                spi_pkg::REG_WAIT_2:   conf_wait[23:16]   <= bus_wdata;
                spi_pkg::REG_WAIT_3:   conf_wait[31:24]   <= bus_wdata;
                spi_pkg::REG_REPEAT_0: conf_repeat[7:0]   <= bus_wdata;
                spi_pkg::REG_REPEAT_1: conf_repeat[15:8]  <= bus_wdata;
                spi_pkg::REG_REPEAT_2: conf_repeat[23:16] <= bus_wdata;
                spi_pkg::REG_REPEAT_3: conf_repeat[31:24] <= bus_wdata;
                default: ;
            endcase
        end
    end

    // low while a run is in progress
    always_ff @(posedge SPI_CLK) begin
        if (RST) begin
            done_flag <= 1'b1;
        end else if (start) begin
            done_flag <= 1'b0;
        end else if (done) begin
            done_flag <= 1'b1;
        end
    end

    always_ff @(posedge SPI_CLK) begin
        case (bus_addr)
            spi_pkg::REG_RESET:    reg_rdata <= 8'(spi_pkg::VERSION);
            spi_pkg::REG_START:    reg_rdata <= {7'd0, done_flag};
            spi_pkg::REG_BITS_LO:  reg_rdata <= conf_bits[7:0];
            spi_pkg::REG_BITS_HI:  reg_rdata <= conf_bits[15:8];
            spi_pkg::REG_WAIT_0:   reg_rdata <= conf_wait[7:0];
            spi_pkg::REG_WAIT_1:   reg_rdata <= conf_wait[15:8];
            spi_pkg::REG_WAIT_2:   reg_rdata <= conf_wait[23:16];
            spi_pkg::REG_WAIT_3:   reg_rdata <= conf_wait[31:24];
            spi_pkg::REG_REPEAT_0: reg_rdata <= conf_repeat[7:0];
            spi_pkg::REG_REPEAT_1: reg_rdata <= conf_repeat[15:8];
            spi_pkg::REG_REPEAT_2: reg_rdata <= conf_repeat[23:16];
            spi_pkg::REG_REPEAT_3: reg_rdata <= conf_repeat[31:24];
            default:               reg_rdata <= 8'h00;
        endcase
    end

    // same latency as the memory byte port
    always_ff @(posedge SPI_CLK) begin
        if (RST) begin
            prev_addr <= '0;
        end else begin
            prev_addr <= bus_addr;
        end
    end

    always_comb begin
        if (prev_addr < spi_pkg::OUT_MEM_BASE) begin
            bus_rdata = reg_rdata;
        end else if (prev_addr < spi_pkg::IN_MEM_BASE) begin
            bus_rdata = out_mem_rdata;
        end else if (prev_addr < spi_pkg::IN_MEM_BASE + spi_pkg::MEM_BYTES) begin
            bus_rdata = in_mem_rdata;
        end else begin
            bus_rdata = 8'h00;  // unmapped
        end
    end

endmodule

// ==== design/spi_pkg.sv ====
/*
 * SPI sequencer shared definitions
 * register map, memory sizes and sequencer states
 */
package spi_pkg;

    localparam int ADDR_W       = 8;
    localparam int MEM_BYTES    = 4;
    localparam int MEM_BITS     = MEM_BYTES * 8;
    localparam int BIT_CNT_W    = 6;
    localparam int VERSION      = 1;
    localparam int OUT_MEM_BASE = 16;
    localparam int IN_MEM_BASE  = 16 + MEM_BYTES;

    // host register addresses
    typedef enum logic [ADDR_W-1:0] {
        REG_RESET    = 8'd0,  // write soft reset, read version
        REG_START    = 8'd1,  // write start, read done flag
        REG_BITS_LO  = 8'd3,
        REG_BITS_HI  = 8'd4,
        REG_WAIT_0   = 8'd5,
        REG_WAIT_1   = 8'd6,
        REG_WAIT_2   = 8'd7,
        REG_WAIT_3   = 8'd8,
        REG_REPEAT_0 = 8'd9,
        REG_REPEAT_1 = 8'd10,
        REG_REPEAT_2 = 8'd11,
        REG_REPEAT_3 = 8'd12
    } reg_addr_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SHIFT,
        SEQ_WAIT
    } seq_state_e;

endpackage
